//--- source/lc3b_types.sv
`default_nettype none

package lc3b_types;

    localparam int word_width   = 16;
    localparam int opcode_width = 4;
    localparam int nzp_width    = 3;

    typedef logic [word_width-1:0] lc3b_word;
    typedef logic [nzp_width-1:0]  lc3b_nzp;

    // encodings as they appear in instr[15:12]
    typedef enum logic [opcode_width-1:0] {
        op_br   = 4'b0000,
        op_add  = 4'b0001,
        op_ldb  = 4'b0010,
        op_stb  = 4'b0011,
        op_jsr  = 4'b0100,
        op_and  = 4'b0101,
        op_ldr  = 4'b0110,
        op_str  = 4'b0111,
        op_rti  = 4'b1000,
        op_not  = 4'b1001,
        op_ldi  = 4'b1010,
        op_sti  = 4'b1011,
        op_jmp  = 4'b1100,
        op_shf  = 4'b1101,
        op_lea  = 4'b1110,
        op_trap = 4'b1111
    } lc3b_opcode;

    typedef struct packed {
        lc3b_opcode opcode;
        lc3b_nzp    nzp;
        logic       mem_read;
        logic       mem_write;
        logic       valid;
    } stage_rec_t;

    // reads as br with nzp 000, so a bubble never redirects
    localparam stage_rec_t bubble_rec = '0;

    typedef enum logic {
        seq_first,   // port serves the instruction in MEM
        seq_second   // port serves the indirect access in MEM_inter
    } mem_seq_t;

endpackage

`default_nettype wire

//--- source/lc3b_decode.sv
`timescale 1ns/100ps
`default_nettype none

module lc3b_decode (
    input  lc3b_types::lc3b_word   instr,
    output lc3b_types::stage_rec_t rec
);
    import lc3b_types::*;

    lc3b_opcode opcode;

    assign opcode = lc3b_opcode'(instr[15:12]);

    always_comb begin
        rec = bubble_rec;
        rec.opcode = opcode;
        rec.nzp = instr[11:9];   // only meaningful for br
        rec.valid = 1'b1;

        case (opcode)
            op_ldb, op_ldi, op_ldr: begin
                rec.mem_read = 1'b1;
            end
            op_stb, op_sti, op_str: begin
                rec.mem_write = 1'b1;
            end
            default: ;
        endcase
    end

endmodule

`default_nettype wire

//--- source/stage_regs.sv
`timescale 1ns/100ps
`default_nettype none

module stage_regs (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   load,
    input  logic                   load_pc,
    input  logic                   control_instruc_ident,
    input  lc3b_types::stage_rec_t id_in,
    output lc3b_types::stage_rec_t id,
    output lc3b_types::stage_rec_t ex,
    output lc3b_types::stage_rec_t mem,
    output lc3b_types::stage_rec_t mem_inter,
    output lc3b_types::stage_rec_t wb
);
    import lc3b_types::*;

    stage_rec_t id_next;

    // the fetched word only counts when the pc moves past it,
    // otherwise it is fetched again later
    always_comb begin
        if (load_pc && !control_instruc_ident) begin
            id_next = id_in;
        end else begin
            id_next = bubble_rec;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            id        <= bubble_rec;
            ex        <= bubble_rec;
            mem       <= bubble_rec;
            mem_inter <= bubble_rec;
            wb        <= bubble_rec;
        end else if (load) begin
            id        <= id_next;
            ex        <= id;
            mem       <= ex;
            mem_inter <= mem;   // every instruction spends a cycle here
            wb        <= mem_inter;
        end
    end

endmodule

`default_nettype wire

//--- source/mem_access_ctrl.sv
`timescale 1ns/100ps
`default_nettype none

module mem_access_ctrl (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   d_mem_resp,
    input  lc3b_types::stage_rec_t mem,
    input  lc3b_types::stage_rec_t mem_inter,
    output logic                   d_mem_read,
    output logic                   d_mem_write,
    output logic                   mem_inter_read,
    output logic                   mem_inter_write
);
    import lc3b_types::*;

    mem_seq_t seq;
    mem_seq_t seq_next;
    logic     mem_read_req;
    logic     mem_write_req;
    logic     indirect_in_mem;

    assign indirect_in_mem = mem.valid && (mem.opcode == op_ldi || mem.opcode == op_sti);

    // MEM slot waits while an indirect access owns the port
    assign mem_read_req    = (seq == seq_first) && mem.valid && mem.mem_read;
    assign mem_write_req   = (seq == seq_first) && mem.valid && mem.mem_write;
    assign mem_inter_read  = (seq == seq_second) && mem_inter.mem_read;
    assign mem_inter_write = (seq == seq_second) && mem_inter.mem_write;

    assign d_mem_read  = mem_read_req | mem_inter_read;
    assign d_mem_write = mem_write_req | mem_inter_write;

    always_comb begin
        seq_next = seq;
        case (seq)
            seq_first: begin
                if (d_mem_resp && indirect_in_mem)
                    seq_next = seq_second;   // pointer fetched, ldi/sti moves on
            end
            seq_second: begin
                if (d_mem_resp)
                    seq_next = seq_first;
            end
            default: seq_next = seq_first;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            seq <= seq_first;
        end else begin
            seq <= seq_next;
        end
    end

endmodule

`default_nettype wire

//--- source/hazard_detection.sv
`timescale 1ns/100ps
`default_nettype none

module hazard_detection (
    input  logic                   br_enable,
    input  logic                   i_mem_resp,
    input  logic                   d_mem_resp,
    input  logic                   d_mem_read,
    input  logic                   d_mem_write,
    input  logic                   mem_inter_read,
    input  logic                   mem_inter_write,
    input  lc3b_types::lc3b_opcode op_id,
    input  lc3b_types::lc3b_opcode op_ex,
    input  lc3b_types::lc3b_opcode op_mem,
    input  lc3b_types::lc3b_opcode op_mem_inter,
    input  lc3b_types::lc3b_opcode op_wb,
    input  lc3b_types::lc3b_nzp    nzp_id,
    input  lc3b_types::lc3b_nzp    nzp_ex,
    input  lc3b_types::lc3b_nzp    nzp_mem,
    input  lc3b_types::lc3b_nzp    nzp_wb,
    output logic                   load,
    output logic                   load_pc,
    output logic                   load_pcbak,
    output logic                   control_instruc_ident,
    output logic                   control_instruc_ident_wb
);
    import lc3b_types::*;

    logic mem_op;
    logic inter_done;
    logic mem_slot_busy;

    // br with nzp 000 never branches, so it does not hold fetch
    function automatic logic is_control(lc3b_opcode op, lc3b_nzp nzp);
        logic ctrl;
        case (op)
            op_br:                   ctrl = (nzp != 3'b000);
            op_jmp, op_jsr, op_trap: ctrl = 1'b1;
            default:                 ctrl = 1'b0;
        endcase
        return ctrl;
    endfunction

    function automatic logic is_mem_opcode(lc3b_opcode op);
        logic hit;
        case (op)
            op_ldb, op_ldi, op_ldr,
            op_stb, op_sti, op_str: hit = 1'b1;
            default:                hit = 1'b0;
        endcase
        return hit;
    endfunction

    assign mem_op = d_mem_read | d_mem_write;

    assign inter_done = (op_mem_inter == op_ldi || op_mem_inter == op_sti)
                     && (mem_inter_read || mem_inter_write) && d_mem_resp;
    assign mem_slot_busy = is_mem_opcode(op_mem);

    always_comb begin
        case ({i_mem_resp, d_mem_resp, mem_op})
            3'b000: begin
                load    = 1'b1;   // no fetch yet, bubble goes in
                load_pc = 1'b0;
            end
            3'b001, 3'b101: begin
                load    = 1'b0;   // data access outstanding
                load_pc = 1'b0;
            end
            3'b010, 3'b110: begin
                load    = 1'b0;
                load_pc = 1'b0;
            end
            3'b011: begin
                load    = 1'b1;
                load_pc = 1'b0;
            end
            default: begin
                load    = 1'b1;
                load_pc = 1'b1;
            end
        endcase

        // the load or store in MEM has not had the port yet, so hold
        // everything one more round after the indirect access ends
        if (inter_done && mem_slot_busy) begin
            load    = 1'b0;
            load_pc = 1'b0;
        end

        if (control_instruc_ident)
            load_pc = 1'b0;
    end

    // catches a redirect whose pc update is lost to a stall
    always_comb begin
        load_pcbak = 1'b0;
        case (op_wb)
            op_br: begin
                if (br_enable && nzp_wb != 3'b000)
                    load_pcbak = 1'b1;
            end
            op_jmp, op_jsr, op_trap: load_pcbak = 1'b1;
            default: ;
        endcase
    end

    assign control_instruc_ident = is_control(op_id, nzp_id)
                                 | is_control(op_ex, nzp_ex)
                                 | is_control(op_mem, nzp_mem);

    assign control_instruc_ident_wb = is_control(op_wb, nzp_wb);

endmodule

`default_nettype wire

//--- source/pc_unit.sv
`timescale 1ns/100ps
`default_nettype none

module pc_unit (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 load_pc,
    input  logic                 load_pcbak,
    input  logic                 control_instruc_ident_wb,
    input  lc3b_types::lc3b_word wb_target,
    output lc3b_types::lc3b_word pc
);
    import lc3b_types::*;

    lc3b_word pc_bak;
    lc3b_word pc_next;
    logic     bak_pending;

    always_comb begin
        if (bak_pending) begin
            pc_next = pc_bak;   // redirect that arrived during a stall
        end else if (control_instruc_ident_wb) begin
            pc_next = wb_target;
        end else begin
            pc_next = pc + lc3b_word'(2);
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            pc          <= '0;
            bak_pending <= 1'b0;
        end else if (load_pc) begin
            pc          <= pc_next;
            bak_pending <= 1'b0;
        end else if (load_pcbak) begin
            bak_pending <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (load_pcbak && !load_pc)
            pc_bak <= wb_target;
    end

endmodule

`default_nettype wire

//--- source/lc3b_pipe_ctrl.sv
`timescale 1ns/100ps
`default_nettype none

module lc3b_pipe_ctrl (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 i_mem_resp,
    input  logic                 d_mem_resp,
    input  logic                 br_enable,
    input  lc3b_types::lc3b_word instr,
    input  lc3b_types::lc3b_word wb_target,
    output lc3b_types::lc3b_word pc,
    output logic                 d_mem_read,
    output logic                 d_mem_write,
    output logic                 stall
);
    import lc3b_types::*;

    stage_rec_t id_in_rec;
    stage_rec_t id_rec;
    stage_rec_t ex_rec;
    stage_rec_t mem_rec;
    stage_rec_t mem_inter_rec;
    stage_rec_t wb_rec;
    logic       load;
    logic       load_pc;
    logic       load_pcbak;
    logic       control_instruc_ident;
    logic       control_instruc_ident_wb;
    logic       mem_inter_read;
    logic       mem_inter_write;

    lc3b_decode lc3b_decode_inst (
        .instr (instr),
        .rec   (id_in_rec)
    );

    stage_regs stage_regs_inst (
        .clk                   (clk),
        .reset                 (reset),
        .load                  (load),
        .load_pc               (load_pc),
        .control_instruc_ident (control_instruc_ident),
        .id_in                 (id_in_rec),
        .id                    (id_rec),
        .ex                    (ex_rec),
        .mem                   (mem_rec),
        .mem_inter             (mem_inter_rec),
        .wb                    (wb_rec)
    );

    mem_access_ctrl mem_access_ctrl_inst (
        .clk             (clk),
        .reset           (reset),
        .d_mem_resp      (d_mem_resp),
        .mem             (mem_rec),
        .mem_inter       (mem_inter_rec),
        .d_mem_read      (d_mem_read),
        .d_mem_write     (d_mem_write),
        .mem_inter_read  (mem_inter_read),
        .mem_inter_write (mem_inter_write)
    );

    hazard_detection hazard_detection_inst (
        .br_enable                (br_enable),
        .i_mem_resp               (i_mem_resp),
        .d_mem_resp               (d_mem_resp),
        .d_mem_read               (d_mem_read),
        .d_mem_write              (d_mem_write),
        .mem_inter_read           (mem_inter_read),
        .mem_inter_write          (mem_inter_write),
        .op_id                    (id_rec.opcode),
        .op_ex                    (ex_rec.opcode),
        .op_mem                   (mem_rec.opcode),
        .op_mem_inter             (mem_inter_rec.opcode),
        .op_wb                    (wb_rec.opcode),
        .nzp_id                   (id_rec.nzp),
        .nzp_ex                   (ex_rec.nzp),
        .nzp_mem                  (mem_rec.nzp),
        .nzp_wb                   (wb_rec.nzp),
        .load                     (load),
        .load_pc                  (load_pc),
        .load_pcbak               (load_pcbak),
        .control_instruc_ident    (control_instruc_ident),
        .control_instruc_ident_wb (control_instruc_ident_wb)
    );

    pc_unit pc_unit_inst (
        .clk                      (clk),
        .reset                    (reset),
        .load_pc                  (load_pc),
        .load_pcbak               (load_pcbak),
        .control_instruc_ident_wb (control_instruc_ident_wb),
        .wb_target                (wb_target),
        .pc                       (pc)
    );

    assign stall = ~load;   // whole pipe frozen this cycle

endmodule

`default_nettype wire

//--- verif/tb_lc3b_pipe_ctrl.sv
`timescale 1ns/100ps
`default_nettype none

module tb_lc3b_pipe_ctrl;

    localparam int max_vectors  = 256;
    localparam int reset_cycles = 16;

    // one clock cycle of stimulus and expected response
    typedef struct packed {
        logic [8*24-1:0] name;
        logic [15:0]     instr;
        logic            i_mem_resp;
        logic            d_mem_resp;
        logic            br_enable;
        logic [15:0]     wb_target;
        logic [15:0]     exp_pc;
        logic            exp_read;
        logic            exp_write;
        logic            exp_stall;
    } vector_t;

    logic        clk;
    logic        reset;
    logic        i_mem_resp;
    logic        d_mem_resp;
    logic        br_enable;
    logic [15:0] instr;
    logic [15:0] wb_target;
    logic [15:0] pc;
    logic        d_mem_read;
    logic        d_mem_write;
    logic        stall;

    vector_t vectors [0:max_vectors-1];
    int      vec_count;
    int      cycle_count;
    int      cycle_limit;
    int      test_errors;
    int      tests_run;
    int      tests_failed;
    int      total_errors;

    lc3b_pipe_ctrl lc3b_pipe_ctrl_inst (
        .clk         (clk),
        .reset       (reset),
        .i_mem_resp  (i_mem_resp),
        .d_mem_resp  (d_mem_resp),
        .br_enable   (br_enable),
        .instr       (instr),
        .wb_target   (wb_target),
        .pc          (pc),
        .d_mem_read  (d_mem_read),
        .d_mem_write (d_mem_write),
        .stall       (stall)
    );

    always #5 clk = ~clk;

    task automatic load_vectors();
        int              fd;
        int              fields;
        string           line_buf;
        logic [8*24-1:0] f_name;
        logic [15:0]     f_instr;
        logic [15:0]     f_target;
        logic [15:0]     f_pc;
        logic            f_imr;
        logic            f_dmr;
        logic            f_bre;
        logic            f_rd;
        logic            f_wr;
        logic            f_stall;
        fd = $fopen("verif/pipe_ctrl_vectors.txt", "r");
        if (fd == 0) begin
            $display("cannot open verif/pipe_ctrl_vectors.txt");
            total_errors++;
        end else begin
            while ($fgets(line_buf, fd) != 0) begin
                if (line_buf.len() > 1 && line_buf[0] != "#" && vec_count < max_vectors) begin
                    fields = $sscanf(line_buf, "%s %h %h %h %h %h %h %h %h %h", f_name,
                                     f_instr, f_imr, f_dmr, f_bre, f_target,
                                     f_pc, f_rd, f_wr, f_stall);
                    if (fields != 10) begin
                        $display("malformed vector line: %s", line_buf);
                        total_errors++;
                    end else begin
                        vectors[vec_count] = {f_name, f_instr, f_imr, f_dmr, f_bre,
                                              f_target, f_pc, f_rd, f_wr, f_stall};
                        vec_count++;
                    end
                end
            end
            $fclose(fd);
        end
        if (vec_count == 0) begin
            $display("no vectors were loaded");
            total_errors++;
        end
    endtask

    task automatic compare_field(input logic [8*24-1:0] test_name, input string field,
                                 input logic [15:0] expected, input logic [15:0] actual,
                                 input int step);
        if (actual !== expected) begin
            $display("ERR %0s step %0d %0s expected %h actual %h",
                     test_name, step, field, expected, actual);
            test_errors++;
            total_errors++;
        end
    endtask

    task automatic report_test(input logic [8*24-1:0] test_name);
        tests_run++;
        if (test_errors == 0) begin
            $display("test %0s ok", test_name);
        end else begin
            $display("test %0s failed with %0d mismatches", test_name, test_errors);
            tests_failed++;
        end
        test_errors = 0;
    endtask

    // run is bounded by the vector count, counted from reset release
    always @(posedge clk) begin
        if (!reset) begin
            cycle_count = cycle_count + 1;
            if (cycle_count > cycle_limit) begin
                $display("timeout: the run went past %0d cycles", cycle_limit);
                $display("Verification failed");
                $finish;
            end
        end
    end

    initial begin
        int idx;
        clk          = 1'b0;
        reset        = 1'b1;
        i_mem_resp   = 1'b0;
        d_mem_resp   = 1'b0;
        br_enable    = 1'b0;
        instr        = '0;
        wb_target    = '0;
        vec_count    = 0;
        cycle_count  = 0;
        test_errors  = 0;
        tests_run    = 0;
        tests_failed = 0;
        total_errors = 0;

        load_vectors();
        cycle_limit = 3 * vec_count;

        repeat (reset_cycles) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        for (idx = 0; idx < vec_count; idx++) begin
            if (idx > 0 && vectors[idx].name != vectors[idx-1].name)
                report_test(vectors[idx-1].name);
            instr      = vectors[idx].instr;   // inputs change on the falling edge
            i_mem_resp = vectors[idx].i_mem_resp;
            d_mem_resp = vectors[idx].d_mem_resp;
            br_enable  = vectors[idx].br_enable;
            wb_target  = vectors[idx].wb_target;
            #2;
            compare_field(vectors[idx].name, "pc", vectors[idx].exp_pc, pc, idx);
            compare_field(vectors[idx].name, "d_mem_read", {15'b0, vectors[idx].exp_read},
                          {15'b0, d_mem_read}, idx);
            compare_field(vectors[idx].name, "d_mem_write", {15'b0, vectors[idx].exp_write},
                          {15'b0, d_mem_write}, idx);
            compare_field(vectors[idx].name, "stall", {15'b0, vectors[idx].exp_stall},
                          {15'b0, stall}, idx);
            @(negedge clk);
        end
        if (vec_count > 0)
            report_test(vectors[vec_count-1].name);

        $display("tests run %0d, tests failed %0d, mismatches %0d",
                 tests_run, tests_failed, total_errors);
        if (total_errors == 0 && tests_failed == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- verif/pipe_ctrl_vectors.txt
# test instr i_mem_resp d_mem_resp br_enable wb_target | pc d_mem_read d_mem_write stall
# one clock cycle per line, all fields hex, the last four are expected outputs
reset_check 0000 0 0 0 0000 0000 0 0 0
alu_run 1021 1 0 0 0000 0000 0 0 0
alu_run 1021 1 0 0 0000 0002 0 0 0
alu_run 1021 1 0 0 0000 0004 0 0 0
alu_run 1021 1 0 0 0000 0006 0 0 0
load_store 6200 1 0 0 0000 0008 0 0 0
load_store 7200 1 0 0 0000 000a 0 0 0
load_store 1021 1 0 0 0000 000c 0 0 0
load_store 1021 1 0 0 0000 000e 1 0 1
load_store 1021 1 0 0 0000 000e 1 0 1
load_store 1021 1 1 0 0000 000e 1 0 0
load_store 1021 1 0 0 0000 0010 0 1 1
load_store 1021 1 1 0 0000 0010 0 1 0
load_store 1021 1 0 0 0000 0012 0 0 0
ldi_indirect a200 1 0 0 0000 0014 0 0 0
ldi_indirect 1021 1 0 0 0000 0016 0 0 0
ldi_indirect 1021 1 0 0 0000 0018 0 0 0
ldi_indirect 1021 1 0 0 0000 001a 1 0 1
ldi_indirect 1021 1 1 0 0000 001a 1 0 0
ldi_indirect 1021 1 0 0 0000 001c 1 0 1
ldi_indirect 1021 1 0 0 0000 001c 1 0 1
ldi_indirect 1021 1 1 0 0000 001c 1 0 0
ldi_indirect 1021 1 0 0 0000 001e 0 0 0
jmp_redirect c080 1 0 0 0000 0020 0 0 0
jmp_redirect 1021 1 0 0 0000 0022 0 0 0
jmp_redirect 1021 1 0 0 0000 0022 0 0 0
jmp_redirect 1021 1 0 0 0000 0022 0 0 0
jmp_redirect 1021 1 0 0 0000 0022 0 0 0
jmp_redirect 1021 1 0 0 0040 0024 0 0 0
jmp_redirect 0000 1 0 0 0000 0040 0 0 0
jmp_redirect 1021 1 0 0 0000 0042 0 0 0
jmp_redirect 1021 1 0 0 0000 0044 0 0 0
jmp_redirect 1021 1 0 0 0000 0046 0 0 0
jmp_sti_backup c080 1 0 0 0000 0048 0 0 0
jmp_sti_backup 1021 1 0 0 0000 004a 0 0 0
jmp_sti_backup 1021 1 0 0 0000 004a 0 0 0
jmp_sti_backup 1021 1 0 0 0000 004a 0 0 0
jmp_sti_backup 1021 1 0 0 0000 004a 0 0 0
jmp_sti_backup 1021 0 0 0 0080 004c 0 0 0
jmp_sti_backup 1021 1 0 0 1234 004c 0 0 0
jmp_sti_backup b200 1 0 0 0000 0080 0 0 0
jmp_sti_backup 1021 1 0 0 0000 0082 0 0 0
jmp_sti_backup 1021 1 0 0 0000 0084 0 0 0
jmp_sti_backup 1021 1 0 0 0000 0086 0 1 1
jmp_sti_backup 1021 1 1 0 0000 0086 0 1 0
jmp_sti_backup 1021 1 0 0 0000 0088 0 1 1
jmp_sti_backup 1021 1 1 0 0000 0088 0 1 0
jmp_sti_backup 1021 1 0 0 0000 008a 0 0 0

//--- flist.f
source/lc3b_types.sv
source/lc3b_decode.sv
source/stage_regs.sv
source/mem_access_ctrl.sv
source/hazard_detection.sv
source/pc_unit.sv
source/lc3b_pipe_ctrl.sv
verif/tb_lc3b_pipe_ctrl.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --timescale 1ns/100ps
TOP       = tb_lc3b_pipe_ctrl
FLIST     = flist.f
OBJ_DIR   = obj_dir
LOG       = sim.log

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR)

run: compile
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "Verification failed" $(LOG); then exit 1; fi
	@grep -q "Verification passed" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
